/* source/csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

`define CSR_XLEN   32  // Data word
`define CSR_ADDR_W 12  // CSR number
`define CSR_CNT_W  64  // mcycle / minstret

//////////////////////////////////////////////////////////////////////
// Reset values, bit positions and masks
//////////////////////////////////////////////////////////////////////

// Writable mie bits: MSIE (3), MTIE (7), MEIE (11)
`define CSR_IRQ_MASK 32'h0000_0888

// MXL=1 (RV32), M (bit 12), I (bit 8), C (bit 2)
`define CSR_MISA_VALUE 32'h4000_1104

`define CSR_MSTATUS_MIE_BIT  3  // Global machine interrupt enable
`define CSR_MSTATUS_MPIE_BIT 7  // Previous MIE, saved on trap entry

`define CSR_MTVEC_RESET 32'h0000_0001  // Base 0, vectored mode

// Implemented inhibit bits: CY (0) and IR (2)
`define CSR_INHIBIT_MASK 32'h0000_0005

`endif

/* source/csr_pkg.sv */
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

  // Implemented CSR numbers
  typedef enum logic [`CSR_ADDR_W-1:0] {
    MSTATUS       = 12'h300,
    MISA          = 12'h301,
    MIE           = 12'h304,
    MTVEC         = 12'h305,
    MCOUNTINHIBIT = 12'h320,
    MSCRATCH      = 12'h340,
    MEPC          = 12'h341,
    MCAUSE        = 12'h342,
    MIP           = 12'h344,
    MCYCLE        = 12'hB00,
    MINSTRET      = 12'hB02,
    MCYCLEH       = 12'hB80,
    MINSTRETH     = 12'hB82,
    MVENDORID     = 12'hF11,  // Read-only ID block, bits 11:10 = 2'b11
    MARCHID       = 12'hF12,
    MIMPID        = 12'hF13,
    MHARTID       = 12'hF14
  } csr_num_e;

  // Legal bus write, one cycle wide
  typedef struct packed {
    logic                 valid;
    csr_num_e             num;
    logic [`CSR_XLEN-1:0] data;
  } csr_wreq_t;

  // Command from the core controller
  typedef struct packed {
    logic                 save_cause;    // Trap entry
    logic                 restore_mret;  // MRET
    logic [`CSR_XLEN-1:0] cause;
    logic [`CSR_XLEN-1:0] exc_pc;
  } trap_ctrl_t;

  // Only MIE and MPIE are implemented
  typedef struct packed {
    logic [23:0] zero2;
    logic        mpie;   // Bit 7
    logic [2:0]  zero1;
    logic        mie;    // Bit 3
    logic [2:0]  zero0;
  } mstatus_t;

  typedef struct packed {
    logic        interrupt;       // 1 for interrupts, 0 for exceptions
    logic [22:0] zero0;
    logic [7:0]  exception_code;
  } mcause_t;

  typedef struct packed {
    logic [29:0] base;  // Word aligned handler base
    logic [1:0]  mode;  // 0 direct, 1 vectored
  } mtvec_t;

endpackage

`default_nettype wire

/* source/csr_apb_slave.sv */
`default_nettype none

`include "csr_defines.svh"

module csr_apb_slave import csr_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // APB side
  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  input  wire logic                   pwrite_i,
  input  wire logic [`CSR_ADDR_W-1:0] paddr_i,
  input  wire logic [`CSR_XLEN-1:0]   pwdata_i,
  output      logic [`CSR_XLEN-1:0]   prdata_o,
  output      logic                   pready_o,
  output      logic                   pslverr_o,
  // Read mux side
  output      csr_num_e               raddr_o,
  input  wire logic [`CSR_XLEN-1:0]   rdata_i,
  input  wire logic                   unknown_addr_i,
  // To both register banks
  output      csr_wreq_t              wreq_o
);

  logic setup_q;      // Previous cycle was a setup phase
  logic access;       // Valid access phase
  logic ro_addr;      // Bits 11:10 both set
  logic refused;

  //////////////////////////////////////////////////////////////////////
  // Phase tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel_i && !penable_i;
    end
  end

  // penable without a setup cycle before it is ignored
  assign access = psel_i && penable_i && setup_q;

  //////////////////////////////////////////////////////////////////////
  // Legality check
  //////////////////////////////////////////////////////////////////////

  assign raddr_o = csr_num_e'(paddr_i);  // Mux decodes the number
  assign ro_addr = (paddr_i[11:10] == 2'b11);

  // Unknown number always refused, read-only number only on writes
  assign refused = unknown_addr_i || (pwrite_i && ro_addr);

  assign pready_o  = 1'b1;                   // No wait states
  assign pslverr_o = access && refused;
  assign prdata_o  = (access && !pwrite_i) ? rdata_i : '0;

  // Write request, fires at the edge that ends the access phase
  always_comb begin
    wreq_o       = '0;
    wreq_o.valid = access && pwrite_i && !refused;
    wreq_o.num   = csr_num_e'(paddr_i);
    wreq_o.data  = pwdata_i;
  end

endmodule

`default_nettype wire

/* source/csr_trap_regs.sv */
`default_nettype none

`include "csr_defines.svh"

module csr_trap_regs import csr_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire csr_wreq_t            wreq_i,      // Bus write
  input  wire trap_ctrl_t           trap_i,      // Controller command
  output      mstatus_t             mstatus_o,
  output      logic [`CSR_XLEN-1:0] mie_o,
  output      mtvec_t               mtvec_o,
  output      logic [`CSR_XLEN-1:0] mscratch_o,
  output      logic [`CSR_XLEN-1:0] mepc_o,
  output      mcause_t              mcause_o
);

  mstatus_t             mstatus_q, mstatus_n;
  logic [`CSR_XLEN-1:0] mie_q, mie_n;
  mtvec_t               mtvec_q, mtvec_n;
  logic [`CSR_XLEN-1:0] mscratch_q, mscratch_n;
  logic [`CSR_XLEN-1:0] mepc_q, mepc_n;
  mcause_t              mcause_q, mcause_n;
  logic [`CSR_XLEN-1:0] wdata;

  assign wdata = wreq_i.data;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_n  = mstatus_q;   // Hold by default
    mie_n      = mie_q;
    mtvec_n    = mtvec_q;
    mscratch_n = mscratch_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;

    // Bus writes, masked to the implemented fields
    if (wreq_i.valid) begin
      case (wreq_i.num)
        MSTATUS: begin
          mstatus_n = '{mie:     wdata[`CSR_MSTATUS_MIE_BIT],
                        mpie:    wdata[`CSR_MSTATUS_MPIE_BIT],
                        default: '0};
        end
        MIE:      mie_n      = wdata & `CSR_IRQ_MASK;
        MTVEC:    mtvec_n    = '{base: wdata[31:2], mode: {1'b0, wdata[0]}};
        MSCRATCH: mscratch_n = wdata;
        MEPC:     mepc_n     = {wdata[31:1], 1'b0};  // Halfword aligned
        MCAUSE: begin
          mcause_n = '{interrupt:      wdata[31],
                       exception_code: wdata[7:0],
                       default:        '0};
        end
        default: ;  // Other numbers live elsewhere
      endcase
    end

    // Controller overrides the bus
    if (trap_i.save_cause) begin
      mstatus_n.mpie = mstatus_q.mie;  // Stack the enable
      mstatus_n.mie  = 1'b0;           // Handler runs with interrupts off
      mepc_n         = {trap_i.exc_pc[31:1], 1'b0};
      mcause_n       = '{interrupt:      trap_i.cause[31],
                         exception_code: trap_i.cause[7:0],
                         default:        '0};
    end else if (trap_i.restore_mret) begin
      mstatus_n.mie  = mstatus_q.mpie;  // Pop the enable
      mstatus_n.mpie = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= '0;                 // Interrupts disabled
      mie_q      <= '0;
      mtvec_q    <= `CSR_MTVEC_RESET;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q  <= mstatus_n;
      mie_q      <= mie_n;
      mtvec_q    <= mtvec_n;
      mscratch_q <= mscratch_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
    end
  end

  assign mstatus_o  = mstatus_q;
  assign mie_o      = mie_q;
  assign mtvec_o    = mtvec_q;
  assign mscratch_o = mscratch_q;
  assign mepc_o     = mepc_q;
  assign mcause_o   = mcause_q;

endmodule

`default_nettype wire

/* source/csr_counters.sv */
`default_nettype none

`include "csr_defines.svh"

module csr_counters import csr_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire csr_wreq_t             wreq_i,
  input  wire logic                  instr_ret_i,     // One pulse per retired instruction
  output      logic [`CSR_CNT_W-1:0] mcycle_o,
  output      logic [`CSR_CNT_W-1:0] minstret_o,
  output      logic [`CSR_XLEN-1:0]  mcountinhibit_o
);

  localparam int unsigned CY_IDX = 0;  // Inhibit bit for mcycle
  localparam int unsigned IR_IDX = 2;  // Inhibit bit for minstret

  logic [`CSR_CNT_W-1:0] mcycle_q, minstret_q;
  logic [`CSR_XLEN-1:0]  inhibit_q;

  logic wr_cy_lo, wr_cy_hi;  // Bus writes to mcycle halves
  logic wr_ir_lo, wr_ir_hi;  // Bus writes to minstret halves
  logic wr_inhibit;
  logic inc_cy, inc_ir;

  // Next value of one counter, a bus write replaces the increment
  function automatic logic [`CSR_CNT_W-1:0] cnt_next(
    input logic [`CSR_CNT_W-1:0] q,
    input logic                  wr_lo,
    input logic                  wr_hi,
    input logic                  inc,
    input logic [`CSR_XLEN-1:0]  d
  );
    logic [`CSR_CNT_W-1:0] n;
    n = q;
    if (wr_lo) begin
      n[`CSR_XLEN-1:0] = d;
    end else if (wr_hi) begin
      n[`CSR_CNT_W-1:`CSR_XLEN] = d;
    end else if (inc) begin
      n = q + `CSR_CNT_W'(1);
    end
    return n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Write decode and increment enables
  //////////////////////////////////////////////////////////////////////

  assign wr_cy_lo   = wreq_i.valid && (wreq_i.num == MCYCLE);
  assign wr_cy_hi   = wreq_i.valid && (wreq_i.num == MCYCLEH);
  assign wr_ir_lo   = wreq_i.valid && (wreq_i.num == MINSTRET);
  assign wr_ir_hi   = wreq_i.valid && (wreq_i.num == MINSTRETH);
  assign wr_inhibit = wreq_i.valid && (wreq_i.num == MCOUNTINHIBIT);

  assign inc_cy = !inhibit_q[CY_IDX];                 // Every cycle
  assign inc_ir = !inhibit_q[IR_IDX] && instr_ret_i;  // Retired instructions only

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
      inhibit_q  <= `CSR_INHIBIT_MASK;  // Both counters stopped after reset
    end else begin
      mcycle_q   <= cnt_next(mcycle_q, wr_cy_lo, wr_cy_hi, inc_cy, wreq_i.data);
      minstret_q <= cnt_next(minstret_q, wr_ir_lo, wr_ir_hi, inc_ir, wreq_i.data);
      if (wr_inhibit) begin
        inhibit_q <= wreq_i.data & `CSR_INHIBIT_MASK;
      end
    end
  end

  assign mcycle_o        = mcycle_q;
  assign minstret_o      = minstret_q;
  assign mcountinhibit_o = inhibit_q;

endmodule

`default_nettype wire

/* source/csr_read_mux.sv */
`default_nettype none

`include "csr_defines.svh"

module csr_read_mux import csr_pkg::*; (
  input  wire csr_num_e              raddr_i,
  // Trap register bank
  input  wire mstatus_t              mstatus_i,
  input  wire logic [`CSR_XLEN-1:0]  mie_i,
  input  wire mtvec_t                mtvec_i,
  input  wire logic [`CSR_XLEN-1:0]  mscratch_i,
  input  wire logic [`CSR_XLEN-1:0]  mepc_i,
  input  wire mcause_t               mcause_i,
  // Counter bank
  input  wire logic [`CSR_CNT_W-1:0] mcycle_i,
  input  wire logic [`CSR_CNT_W-1:0] minstret_i,
  input  wire logic [`CSR_XLEN-1:0]  mcountinhibit_i,
  // Core inputs
  input  wire logic [`CSR_XLEN-1:0]  mip_i,
  input  wire logic [`CSR_XLEN-1:0]  hart_id_i,
  output      logic [`CSR_XLEN-1:0]  rdata_o,
  output      logic                  unknown_addr_o
);

  always_comb begin
    unknown_addr_o = 1'b0;
    case (raddr_i)
      MSTATUS:       rdata_o = mstatus_i;
      MISA:          rdata_o = `CSR_MISA_VALUE;
      MIE:           rdata_o = mie_i;
      MTVEC:         rdata_o = mtvec_i;
      MSCRATCH:      rdata_o = mscratch_i;
      MEPC:          rdata_o = mepc_i;
      MCAUSE:        rdata_o = mcause_i;
      MIP:           rdata_o = mip_i;      // Pending lines straight from the core
      MHARTID:       rdata_o = hart_id_i;
      // Identity registers read as zero
      MVENDORID,
      MARCHID,
      MIMPID:        rdata_o = '0;
      MCOUNTINHIBIT: rdata_o = mcountinhibit_i;
      MCYCLE:        rdata_o = mcycle_i[`CSR_XLEN-1:0];
      MCYCLEH:       rdata_o = mcycle_i[`CSR_CNT_W-1:`CSR_XLEN];
      MINSTRET:      rdata_o = minstret_i[`CSR_XLEN-1:0];
      MINSTRETH:     rdata_o = minstret_i[`CSR_CNT_W-1:`CSR_XLEN];
      default: begin
        rdata_o        = '0;    // Unimplemented number
        unknown_addr_o = 1'b1;  // Slave turns this into pslverr
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/csr_top.sv */
`default_nettype none

`include "csr_defines.svh"

module csr_top import csr_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // APB
  input  wire logic [`CSR_ADDR_W-1:0] paddr_i,
  input  wire logic                   psel_i,
  input  wire logic                   penable_i,
  input  wire logic                   pwrite_i,
  input  wire logic [`CSR_XLEN-1:0]   pwdata_i,
  output      logic [`CSR_XLEN-1:0]   prdata_o,
  output      logic                   pready_o,
  output      logic                   pslverr_o,
  // Core
  input  wire trap_ctrl_t             trap_i,
  input  wire logic                   instr_ret_i,
  input  wire logic [`CSR_XLEN-1:0]   mip_i,
  input  wire logic [`CSR_XLEN-1:0]   hart_id_i,
  output      logic                   m_irq_enable_o,
  output      logic [`CSR_XLEN-1:0]   mie_o,
  output      mtvec_t                 mtvec_o,
  output      logic [`CSR_XLEN-1:0]   mepc_o
);

  csr_wreq_t             wreq;
  csr_num_e              raddr;
  logic [`CSR_XLEN-1:0]  rdata;
  logic                  unknown_addr;
  mstatus_t              mstatus;
  logic [`CSR_XLEN-1:0]  mscratch;
  mcause_t               mcause;
  logic [`CSR_CNT_W-1:0] mcycle, minstret;
  logic [`CSR_XLEN-1:0]  mcountinhibit;

  assign m_irq_enable_o = mstatus.mie;

  csr_apb_slave u_apb (
    .clk, .rst_n, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .raddr_o (raddr), .rdata_i (rdata), .unknown_addr_i (unknown_addr),
    .wreq_o (wreq)
  );

  csr_trap_regs u_trap (
    .clk, .rst_n, .wreq_i (wreq), .trap_i,
    .mstatus_o (mstatus), .mie_o, .mtvec_o, .mscratch_o (mscratch),
    .mepc_o, .mcause_o (mcause)
  );

  csr_counters u_cnt (
    .clk, .rst_n, .wreq_i (wreq), .instr_ret_i,
    .mcycle_o (mcycle), .minstret_o (minstret), .mcountinhibit_o (mcountinhibit)
  );

  csr_read_mux u_rmux (
    .raddr_i (raddr), .mstatus_i (mstatus), .mie_i (mie_o), .mtvec_i (mtvec_o),
    .mscratch_i (mscratch), .mepc_i (mepc_o), .mcause_i (mcause),
    .mcycle_i (mcycle), .minstret_i (minstret), .mcountinhibit_i (mcountinhibit),
    .mip_i, .hart_id_i, .rdata_o (rdata), .unknown_addr_o (unknown_addr)
  );

endmodule

`default_nettype wire

/* testbench/csr_tb_assertions.sv */
`default_nettype none

`include "csr_defines.svh"

module csr_tb_assertions import csr_pkg::*; (
  input wire logic                 clk,
  input wire logic                 rst_n,
  input wire logic                 psel_i,
  input wire logic                 penable_i,
  input wire logic                 pready_o,
  input wire logic                 pslverr_o,
  input wire logic                 m_irq_enable_o,
  input wire logic [`CSR_XLEN-1:0] mepc_o,
  input wire trap_ctrl_t           trap_i
);

  int fail_count = 0;  // Summed into the testbench totals

  // Error response only in an access phase
  slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr_o |-> (psel_i && penable_i))
    else begin
      $error("pslverr_o high outside an APB access phase");
      fail_count++;
    end

  // No wait states
  ready_high: assert property (@(posedge clk) disable iff (!rst_n) pready_o)
    else begin
      $error("pready_o low after reset");
      fail_count++;
    end

  mepc_aligned: assert property (@(posedge clk) disable iff (!rst_n) !mepc_o[0])
    else begin
      $error("mepc_o bit 0 set");
      fail_count++;
    end

  // Trap entry clears the global enable one cycle later
  irq_off_after_trap: assert property (@(posedge clk) disable iff (!rst_n)
    trap_i.save_cause |=> !m_irq_enable_o)
    else begin
      $error("m_irq_enable_o still high after trap entry");
      fail_count++;
    end

endmodule

bind csr_top csr_tb_assertions u_sva (
  .clk, .rst_n, .psel_i, .penable_i, .pready_o, .pslverr_o,
  .m_irq_enable_o, .mepc_o, .trap_i
);

`default_nettype wire

/* testbench/csr_tb.sv */
`default_nettype none

`include "csr_defines.svh"

module csr_tb import csr_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int APB_OPS      = 80;  // Upper bound on transfers of 3 cycles each
  localparam int WATCHDOG     = RESET_CYCLES + 3 * APB_OPS + 40 + 200;  // Pulses plus margin
  localparam logic [31:0] MIE_M  = 32'h1 << `CSR_MSTATUS_MIE_BIT;
  localparam logic [31:0] MPIE_M = 32'h1 << `CSR_MSTATUS_MPIE_BIT;

  logic clk, rst_n, psel, penable, pwrite, pready, pslverr, instr_ret, irq_en;
  logic [`CSR_ADDR_W-1:0] paddr;
  logic [`CSR_XLEN-1:0]   pwdata, prdata, mip, hart_id, mie_out, mepc_out;
  mtvec_t                 mtvec_out;
  trap_ctrl_t             trap;
  int                     errors = 0;
  int                     checks = 0;
  int                     cycle_cnt = 0;
  int                     sample_cycle;  // Cycle of the last access phase
  logic [31:0]            seed = 32'd20307;

  csr_top UUT (
    .clk, .rst_n, .paddr_i (paddr), .psel_i (psel), .penable_i (penable),
    .pwrite_i (pwrite), .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready),
    .pslverr_o (pslverr), .trap_i (trap), .instr_ret_i (instr_ret), .mip_i (mip),
    .hart_id_i (hart_id), .m_irq_enable_o (irq_en), .mie_o (mie_out),
    .mtvec_o (mtvec_out), .mepc_o (mepc_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // APB and controller drivers
  ////////////////////////////////////////////////////////////////////

  task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk);  // Setup phase
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);  // Access phase
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk);
    rdata        = prdata;
    err          = pslverr;
    sample_cycle = cycle_cnt;
    @(posedge clk);  // Transfer completes here
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] d, input logic exp_err);
    logic [31:0] unused;
    logic        err;
    apb_transfer(1'b1, addr, d, unused, err);
    check_value("pslverr_o", err, exp_err);
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] d);
    logic err;
    apb_transfer(1'b0, addr, '0, d, err);
    check_value("pslverr_o", err, 1'b0);
  endtask

  task automatic read_check(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] d;
    read_csr(addr, d);
    check_value(name, d, exp);
  endtask

  task automatic write_read(input string name, input logic [11:0] addr,
                            input logic [31:0] d, input logic [31:0] exp);
    write_csr(addr, d, 1'b0);
    read_check(name, addr, exp);
  endtask

  task automatic pulse_trap(input logic save, input logic mret, input logic [31:0] cause,
                            input logic [31:0] pc);
    @(posedge clk);
    trap <= '{save_cause: save, restore_mret: mret, cause: cause, exc_pc: pc};
    @(posedge clk);
    trap <= '0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] d, v0, v1, cause, pc;
    logic        err;
    int          c0, n;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    trap      = '0;
    instr_ret = 1'b0;
    mip       = 32'h0000_0880;
    hart_id   = 32'h0000_0003;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n     <= 1'b1;
    instr_ret <= 1'b1;  // Retiring every cycle while still inhibited

    // Counters frozen after reset and free running once enabled
    read_check("mcycle", MCYCLE, '0);
    read_check("minstret", MINSTRET, '0);
    instr_ret <= 1'b0;
    write_read("mcountinhibit", MCOUNTINHIBIT, '0, '0);
    read_csr(MCYCLE, v0);
    c0 = sample_cycle;
    read_csr(MCYCLE, v1);
    check_value("mcycle delta", v1 - v0, sample_cycle - c0);
    read_csr(MINSTRET, v0);
    seed = lcg_next(seed);
    n    = 5 + seed[18:16];
    repeat (n) begin
      @(posedge clk);
      instr_ret <= 1'b1;
      @(posedge clk);
      instr_ret <= 1'b0;
    end
    read_csr(MINSTRET, v1);
    check_value("minstret delta", v1 - v0, n);

    // Random writes with field masks
    repeat (4) begin
      seed = lcg_next(seed);
      write_read("mscratch", MSCRATCH, seed, seed);
      seed = lcg_next(seed);
      write_read("mie", MIE, seed, seed & `CSR_IRQ_MASK);
      check_value("mie_o", mie_out, seed & `CSR_IRQ_MASK);
      seed = lcg_next(seed);
      write_read("mepc", MEPC, seed, seed & ~32'h1);
      seed = lcg_next(seed);
      write_read("mtvec", MTVEC, seed, {seed[31:2], 1'b0, seed[0]});
      check_value("mtvec_o", mtvec_out, {seed[31:2], 1'b0, seed[0]});
      seed = lcg_next(seed);
      write_read("mstatus", MSTATUS, seed, seed & (MIE_M | MPIE_M));
      @(negedge clk);
      check_value("m_irq_enable_o", irq_en, seed[`CSR_MSTATUS_MIE_BIT]);
    end

    // Refused accesses and identity registers
    read_check("mhartid", MHARTID, hart_id);
    write_csr(MHARTID, 32'hDEAD_BEEF, 1'b1);
    read_check("mhartid", MHARTID, hart_id);
    apb_transfer(1'b0, 12'h7C0, '0, d, err);
    check_value("pslverr_o", err, 1'b1);
    check_value("prdata_o", d, '0);
    read_check("misa", MISA, `CSR_MISA_VALUE);
    read_check("mvendorid", MVENDORID, '0);
    read_check("mip", MIP, mip);  // Pending lines pass straight through

    // Trap entry then MRET
    write_read("mstatus", MSTATUS, MIE_M, MIE_M);
    seed  = lcg_next(seed);
    cause = {seed[31], 23'b0, seed[7:0]};
    seed  = lcg_next(seed);
    pc    = seed | 32'h1;  // Odd pc so trap entry has to clear bit 0
    pulse_trap(1'b1, 1'b0, cause, pc);
    @(negedge clk);
    check_value("m_irq_enable_o", irq_en, 1'b0);
    check_value("mepc_o", mepc_out, pc & ~32'h1);
    read_check("mepc", MEPC, pc & ~32'h1);
    read_check("mcause", MCAUSE, cause);
    read_check("mstatus", MSTATUS, MPIE_M);
    pulse_trap(1'b0, 1'b1, '0, '0);
    read_check("mstatus", MSTATUS, MIE_M | MPIE_M);

    // High word write costs the low word one count
    read_csr(MCYCLE, v0);
    c0   = sample_cycle;
    seed = lcg_next(seed);
    write_read("mcycleh", MCYCLEH, seed, seed);
    read_csr(MCYCLE, v1);
    check_value("mcycle delta", v1 - v0, sample_cycle - c0 - 1);

    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, UUT.u_sva.fail_count);
    if (errors == 0 && UUT.u_sva.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+source
source/csr_pkg.sv
source/csr_apb_slave.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_read_mux.sv
source/csr_top.sv
testbench/csr_tb_assertions.sv
testbench/csr_tb.sv
